// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check sim.log"
	@echo "make clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
		--top-module tb_conv_point -f build.f
	./obj_dir/Vtb_conv_point > sim.log 2>&1 || true
	@cat sim.log
	@if grep -qF "*** TEST FAILED ***" sim.log; then exit 1; fi
	@grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

// File: build.f
+incdir+.
conv_pkg.sv
conv_reg_decode.sv
conv_mac_execute.sv
conv_sat_result.sv
conv_point_top.sv
tb_conv_point.sv

// File: conv_consts.svh
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// data widths
`define FT_W        16 // features, weights and linear/act parameters
`define PRL_CHN_N   4  // channels carried per beat
`define ACC_W       40 // point accumulator
`define EXT_INT_W   4  // integer guard bits ahead of saturation

// fixed point fraction bits
`define FT_QUAZ_ACC 10 // features, weights and lin_b
`define AB_QUAZ_ACC 12 // lin_a
`define C_QUAZ_ACC  14 // leaky relu rate

// register map, 4 bit address
`define REG_CTRL    4'd0 // bit 0 enables calculation
`define REG_KW0     4'd1
`define REG_KW1     4'd2
`define REG_KW2     4'd3
`define REG_KW3     4'd4
`define REG_LIN_A   4'd5
`define REG_LIN_B   4'd6
`define REG_ACT_C   4'd7
`define REG_ITR_TH  4'd8
`define REG_ITR_CLR 4'd9 // write only, clears itr and counter

`endif

// File: conv_mac_execute.sv
`timescale 1ns/10ps
`include "conv_consts.svh"

module conv_mac_execute (
	input  logic                clk,
	input  logic                rst_n,
	input  conv_pkg::conv_cfg_t cfg,
	input  logic                in_valid,
	input  conv_pkg::ft_group_t in_group,
	output conv_pkg::pre_sat_t  pre_sat
);

	localparam int PROD_W = 2 * `FT_W;
	localparam int LIN_W = `ACC_W + `FT_W;
	localparam int ACT_W = LIN_W + `FT_W;
	localparam int PRE_W = `EXT_INT_W + `FT_W;
	localparam int HANDOFF_LAT = conv_pkg::ST_OUT - conv_pkg::ST_MUL;

	logic accept;
	logic signed [PROD_W-1:0] prod [`PRL_CHN_N];
	logic s0_vld;
	logic s0_last;
	logic signed [`ACC_W-1:0] chn_sum;
	logic signed [`ACC_W-1:0] acc;
	logic acc_first; // next beat opens a new point
	logic s1_done;
	logic signed [`ACC_W-1:0] acc_scaled;
	logic signed [LIN_W-1:0] lin_prod;
	logic signed [LIN_W-1:0] lin_sum;
	logic signed [LIN_W-1:0] lin_q;
	logic s2_done;
	logic signed [ACT_W-1:0] act_prod;
	logic signed [ACT_W-1:0] act_scaled;
	logic [PRE_W-1:0] act_val;
	logic [PRE_W-1:0] act_q;
	logic s3_done;

	assign accept = in_valid & cfg.en; // beats while disabled are dropped

	// ST_MUL
	always_ff @(posedge clk) begin
		if (accept) begin
			for (int i = 0; i < `PRL_CHN_N; i++) begin
				prod[i] <= $signed(in_group.ft[i]) * $signed(cfg.kw[i]);
			end
		end
	end

	// ST_ACC, sum the lanes then fold into the running point
	always_comb begin
		chn_sum = '0;
		for (int i = 0; i < `PRL_CHN_N; i++) begin
			chn_sum = chn_sum + prod[i];
		end
	end

	always_ff @(posedge clk) begin
		if (s0_vld) begin
			acc <= acc_first ? chn_sum : acc + chn_sum;
		end
	end

	// ST_LIN
	assign acc_scaled = acc >>> `FT_QUAZ_ACC; // back to feature precision
	assign lin_prod = acc_scaled * $signed(cfg.lin_a);
	assign lin_sum = (lin_prod >>> `AB_QUAZ_ACC) + $signed(cfg.lin_b);

	always_ff @(posedge clk) begin
		if (s1_done) begin
			lin_q <= lin_sum;
		end
	end

	// ST_ACT, leaky slope only below zero
	assign act_prod = lin_q * $signed(cfg.act_c);
	assign act_scaled = act_prod >>> `C_QUAZ_ACC;
	assign act_val = lin_q[LIN_W-1] ? act_scaled[PRE_W-1:0] : lin_q[PRE_W-1:0]; // wraps

	always_ff @(posedge clk) begin
		if (s2_done) begin
			act_q <= act_val;
		end
	end

	// stage valids and point framing
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s0_vld <= 1'b0;
			s0_last <= 1'b0;
			acc_first <= 1'b1;
			s1_done <= 1'b0;
			s2_done <= 1'b0;
			s3_done <= 1'b0;
		end else begin
			s0_vld <= accept;
			s0_last <= in_group.last;
			if (s0_vld) begin
				acc_first <= s0_last;
			end
			s1_done <= s0_vld & s0_last; // acc holds a whole point
			s2_done <= s1_done;
			s3_done <= s2_done;
		end
	end

	// ST_OUT
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pre_sat <= '0;
		end else begin
			pre_sat.valid <= s3_done;
			pre_sat.data <= act_q;
		end
	end

	// last beat registered in ST_MUL reaches the hand off exactly four stages later
	a_handoff_lat: assert property (@(posedge clk) disable iff (!rst_n)
		pre_sat.valid == $past(s0_vld && s0_last, HANDOFF_LAT));

endmodule

// File: conv_pkg.sv
`include "conv_consts.svh"

package conv_pkg;

	typedef enum logic [3:0] {
		REG_CTRL    = `REG_CTRL,
		REG_KW0     = `REG_KW0,
		REG_KW1     = `REG_KW1,
		REG_KW2     = `REG_KW2,
		REG_KW3     = `REG_KW3,
		REG_LIN_A   = `REG_LIN_A,
		REG_LIN_B   = `REG_LIN_B,
		REG_ACT_C   = `REG_ACT_C,
		REG_ITR_TH  = `REG_ITR_TH,
		REG_ITR_CLR = `REG_ITR_CLR
	} reg_addr_e;

	// execute pipeline, one register stage each
	typedef enum logic [2:0] {
		ST_MUL = 3'd0, // lane products
		ST_ACC = 3'd1, // channel sum + point accumulation
		ST_LIN = 3'd2, // rescale, a*x+b
		ST_ACT = 3'd3, // leaky relu
		ST_OUT = 3'd4  // hand off to saturation
	} act_stage_e;

	typedef struct packed {
		logic [`PRL_CHN_N-1:0][`FT_W-1:0] ft; // lane 0 in low bits
		logic last; // final channel group of the point
	} ft_group_t;

	typedef struct packed {
		logic en;
		logic [`PRL_CHN_N-1:0][`FT_W-1:0] kw; // one 1x1 weight per lane
		logic [`FT_W-1:0] lin_a;
		logic [`FT_W-1:0] lin_b;
		logic [`FT_W-1:0] act_c;
		logic [15:0] itr_th; // 0 keeps the interrupt off
	} conv_cfg_t;

	typedef struct packed {
		logic [`EXT_INT_W+`FT_W-1:0] data; // signed, FT_QUAZ_ACC fraction
		logic valid;
	} pre_sat_t;

	typedef struct packed {
		logic [`FT_W-1:0] data;
		logic up_ovf;
		logic down_ovf;
	} conv_res_t;

endpackage

// File: conv_point_top.sv
`timescale 1ns/10ps

module conv_point_top (
	input  logic                clk,
	input  logic                rst_n,
	// register writes
	input  logic                cfg_wr,
	input  conv_pkg::reg_addr_e cfg_addr,
	input  logic [31:0]         cfg_wdata,
	// channel group stream, no back pressure
	input  logic                in_valid,
	input  conv_pkg::ft_group_t in_group,
	// one result per point
	output logic                out_valid,
	output conv_pkg::conv_res_t out_res,
	output logic                itr
);

	conv_pkg::conv_cfg_t cfg;
	logic itr_clr;
	conv_pkg::pre_sat_t pre_sat;

	conv_reg_decode u_reg_decode (
		.clk(clk),
		.rst_n(rst_n),
		.cfg_wr(cfg_wr),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg(cfg),
		.itr_clr(itr_clr)
	);

	// multiply, accumulate, rescale, a*x+b and leaky relu
	conv_mac_execute u_mac_execute (
		.clk(clk),
		.rst_n(rst_n),
		.cfg(cfg),
		.in_valid(in_valid),
		.in_group(in_group),
		.pre_sat(pre_sat)
	);

	conv_sat_result u_sat_result (
		.clk(clk),
		.rst_n(rst_n),
		.cfg(cfg),
		.itr_clr(itr_clr),
		.pre_sat(pre_sat),
		.out_valid(out_valid),
		.out_res(out_res),
		.itr(itr)
	);

endmodule

// File: conv_point_vectors.txt
# W addr data | B f0 f1 f2 f3 last | E name data up_ovf down_ovf
# I name itr_level | X name  (hex; weights 1.0 0.5 -1.0 0.25, a 1.5, b 0.125, c 0.25)
W 1 0400
W 2 0200
W 3 fc00
W 4 0100
W 5 1800
W 6 0080
W 7 1000
W 0 1
B 0800 0400 0200 0400 1
E one_beat 0e00 0 0
B 0400 0400 0400 0400 0
B 0200 0800 0000 0400 0
B 0c00 0000 0400 0000 1
B 0400 0400 0000 0000 1
E multi_beat 1b80 0 0
E back_to_back 0980 0 0
B 0000 0000 0c00 0000 1
E leaky_neg fba0 0 0
B 7fff 7fff 0000 7fff 1
E sat_up 7fff 1 0
B 8000 8000 7fff 8000 0
B 8000 8000 7fff 8000 1
E sat_down 8000 0 1
W 0 0
B 0800 0400 0200 0400 1
B 0400 0400 0400 0400 1
X ctrl_off
W 0 1
W 8 3
W 9 0
B 0800 0400 0200 0400 1
B 0800 0400 0200 0400 1
E itr_pt1 0e00 0 0
E itr_pt2 0e00 0 0
I itr_low_at_2 0
B 0800 0400 0200 0400 1
E itr_pt3 0e00 0 0
I itr_high_at_3 1
W 9 0
I itr_cleared 0
B 0800 0400 0200 0400 1
B 0800 0400 0200 0400 1
B 0800 0400 0200 0400 1
E itr_pt4 0e00 0 0
E itr_pt5 0e00 0 0
E itr_pt6 0e00 0 0
I itr_recount 1

// File: conv_reg_decode.sv
`timescale 1ns/10ps
`include "conv_consts.svh"

module conv_reg_decode (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  cfg_wr,
	input  conv_pkg::reg_addr_e   cfg_addr,
	input  logic [31:0]           cfg_wdata,
	output conv_pkg::conv_cfg_t   cfg,
	output logic                  itr_clr
);

	logic [`FT_W-1:0] wr_par; // parameter registers keep the low half

	assign wr_par = cfg_wdata[`FT_W-1:0];

	// configuration registers, all zero after reset so calculation is off
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg <= '0;
		end else if (cfg_wr) begin
			case (cfg_addr)
				conv_pkg::REG_CTRL: begin
					cfg.en <= cfg_wdata[0];
				end
				conv_pkg::REG_KW0: begin
					cfg.kw[0] <= wr_par;
				end
				conv_pkg::REG_KW1: begin
					cfg.kw[1] <= wr_par;
				end
				conv_pkg::REG_KW2: begin
					cfg.kw[2] <= wr_par;
				end
				conv_pkg::REG_KW3: begin
					cfg.kw[3] <= wr_par;
				end
				conv_pkg::REG_LIN_A: begin
					cfg.lin_a <= wr_par;
				end
				conv_pkg::REG_LIN_B: begin
					cfg.lin_b <= wr_par;
				end
				conv_pkg::REG_ACT_C: begin
					cfg.act_c <= wr_par;
				end
				conv_pkg::REG_ITR_TH: begin
					cfg.itr_th <= cfg_wdata[15:0];
				end
				default: begin
					cfg <= cfg; // ITR_CLR only pulses, nothing stored
				end
			endcase
		end
	end

	// one cycle clear strobe toward the interrupt counter
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			itr_clr <= 1'b0;
		end else begin
			itr_clr <= cfg_wr && (cfg_addr == conv_pkg::REG_ITR_CLR);
		end
	end

	// host must stay inside the register map
	a_wr_addr_in_map: assert property (@(posedge clk) disable iff (!rst_n)
		cfg_wr |-> (cfg_addr <= conv_pkg::REG_ITR_CLR));

endmodule

// File: conv_sat_result.sv
`timescale 1ns/10ps
`include "conv_consts.svh"

module conv_sat_result (
	input  logic                clk,
	input  logic                rst_n,
	input  conv_pkg::conv_cfg_t cfg,
	input  logic                itr_clr,
	input  conv_pkg::pre_sat_t  pre_sat,
	output logic                out_valid,
	output conv_pkg::conv_res_t out_res,
	output logic                itr
);

	localparam int PRE_W = `EXT_INT_W + `FT_W;

	logic sign;
	logic [`EXT_INT_W-2:0] ext_bits; // guard bits below the sign
	logic up_ovf;
	logic down_ovf;
	logic [`FT_W-1:0] sat_data;
	logic [15:0] res_cnt;
	logic [15:0] cnt_inc;

	assign sign = pre_sat.data[PRE_W-1];
	assign ext_bits = pre_sat.data[PRE_W-2:`FT_W];

	// guard bits must all match the sign to fit the output format
	assign up_ovf = ~sign & (|ext_bits);
	assign down_ovf = sign & ~(&ext_bits);

	always_comb begin
		if (up_ovf) begin
			sat_data = {1'b0, {(`FT_W-1){1'b1}}}; // 0x7fff
		end else if (down_ovf) begin
			sat_data = {1'b1, {(`FT_W-1){1'b0}}}; // 0x8000
		end else begin
			sat_data = pre_sat.data[`FT_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (pre_sat.valid) begin
			out_res.data <= sat_data;
			out_res.up_ovf <= up_ovf;
			out_res.down_ovf <= down_ovf;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= pre_sat.valid;
		end
	end

	// finished result counter holds the interrupt until cleared
	assign cnt_inc = res_cnt + 16'd1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			res_cnt <= 16'd0;
			itr <= 1'b0;
		end else if (itr_clr) begin
			res_cnt <= 16'd0;
			itr <= 1'b0;
		end else if (out_valid) begin
			res_cnt <= cnt_inc;
			if ((cfg.itr_th != 16'd0) && (cnt_inc == cfg.itr_th)) begin
				itr <= 1'b1;
			end
		end
	end

	a_ovf_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> !(out_res.up_ovf && out_res.down_ovf));

endmodule

// File: tb_conv_point.sv
`timescale 1ns/10ps
`include "conv_consts.svh"

module tb_conv_point;

	localparam int RES_TIMEOUT = 40; // cycles allowed for a result to show up
	localparam int ITR_TIMEOUT = 10;
	localparam int SILENT_WIN = 20;
	localparam int ITR_HOLD = 4;
	localparam int OUT_LAT = 7; // drive edge to the negedge that sees out_valid

	logic clk;
	logic rst_n;
	logic cfg_wr;
	conv_pkg::reg_addr_e cfg_addr;
	logic [31:0] cfg_wdata;
	logic in_valid;
	conv_pkg::ft_group_t in_group;
	logic out_valid;
	conv_pkg::conv_res_t out_res;
	logic itr;

	int cyc = 0;
	bit calc_en;
	bit aborted;
	int pass_cnt;
	int fail_cnt;
	conv_pkg::conv_res_t res_q[$];
	int res_cyc_q[$];
	int exp_cyc_q[$]; // cycle each accepted point should come out

	conv_point_top u_conv_point_top (
		.clk(clk),
		.rst_n(rst_n),
		.cfg_wr(cfg_wr),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.in_valid(in_valid),
		.in_group(in_group),
		.out_valid(out_valid),
		.out_res(out_res),
		.itr(itr)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// collect results on the falling edge, away from the DUT updates
	always @(negedge clk) begin
		if (rst_n && out_valid) begin
			res_q.push_back(out_res);
			res_cyc_q.push_back(cyc);
		end
	end

	task automatic report_test(input string name, input bit ok);
		if (ok) begin
			pass_cnt++;
			$display("%-16s pass", name);
		end else begin
			fail_cnt++;
			$display("%-16s fail", name);
		end
	endtask

	task automatic go_idle();
		@(posedge clk);
		cfg_wr <= 1'b0;
		in_valid <= 1'b0;
	endtask

	task automatic drive_write(input logic [3:0] addr, input logic [31:0] data);
		@(posedge clk);
		cfg_wr <= 1'b1;
		cfg_addr <= conv_pkg::reg_addr_e'(addr);
		cfg_wdata <= data;
		in_valid <= 1'b0;
		if (addr == `REG_CTRL) begin
			calc_en = data[0]; // own copy of the enable bit
		end
	endtask

	task automatic drive_beat(input logic [`PRL_CHN_N-1:0][`FT_W-1:0] ft, input logic last);
		@(posedge clk);
		cfg_wr <= 1'b0;
		in_valid <= 1'b1;
		in_group.ft <= ft;
		in_group.last <= last;
		if (calc_en && last) begin
			exp_cyc_q.push_back(cyc + OUT_LAT);
		end
	endtask

	task automatic check_result(input string name, input logic [15:0] exp_data,
			input logic exp_up, input logic exp_down);
		int waited;
		int got_cyc;
		int exp_cyc;
		bit ok;
		conv_pkg::conv_res_t got;
		waited = 0;
		ok = 1'b1;
		go_idle();
		while (res_q.size() == 0 && waited < RES_TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (res_q.size() == 0) begin
			$display("TIMEOUT %s: no out_valid within %0d cycles", name, RES_TIMEOUT);
			aborted = 1'b1;
			fail_cnt++;
		end else begin
			got = res_q.pop_front();
			got_cyc = res_cyc_q.pop_front();
			if (exp_cyc_q.size() == 0) begin
				$display("ERROR %s: out_valid came without an accepted last beat", name);
				ok = 1'b0;
			end else begin
				exp_cyc = exp_cyc_q.pop_front();
				if (got_cyc != exp_cyc) begin
					$display("ERROR %s: out cycle expected %0d actual %0d", name, exp_cyc,
						got_cyc);
					ok = 1'b0;
				end
			end
			if (got.data !== exp_data) begin
				$display("ERROR %s: data expected %h actual %h", name, exp_data, got.data);
				ok = 1'b0;
			end
			if ({got.up_ovf, got.down_ovf} !== {exp_up, exp_down}) begin
				$display("ERROR %s: up/down ovf expected %b%b actual %b%b", name, exp_up,
					exp_down, got.up_ovf, got.down_ovf);
				ok = 1'b0;
			end
			report_test(name, ok);
		end
	endtask

	task automatic check_itr(input string name, input logic level);
		int waited;
		bit ok;
		waited = 0;
		ok = 1'b1;
		go_idle();
		do begin
			@(negedge clk);
			waited++;
		end while (itr !== level && waited < ITR_TIMEOUT);
		if (itr !== level) begin
			$display("ERROR %s: itr expected %b actual %b", name, level, itr);
			ok = 1'b0;
		end
		// low level must hold a while, catches an early interrupt
		for (int i = 0; i < ITR_HOLD && ok && !level; i++) begin
			@(negedge clk);
			if (itr !== 1'b0) begin
				$display("ERROR %s: itr expected 0 actual %b", name, itr);
				ok = 1'b0;
			end
		end
		report_test(name, ok);
	endtask

	task automatic check_silent(input string name);
		bit ok;
		ok = 1'b1;
		go_idle();
		for (int i = 0; i < SILENT_WIN; i++) begin
			@(negedge clk);
			if (out_valid !== 1'b0) begin
				ok = 1'b0;
			end
		end
		if (!ok) begin
			$display("ERROR %s: out_valid pulsed while calculation was disabled", name);
		end
		report_test(name, ok);
	endtask

	initial begin
		int fd;
		string line;
		string tag;
		string name;
		logic [31:0] a;
		logic [31:0] d;
		logic [15:0] f0, f1, f2, f3;
		logic lst;
		logic up;
		logic dn;
		int n;
		clk = 1'b0;
		rst_n = 1'b0;
		cfg_wr = 1'b0;
		cfg_addr = conv_pkg::REG_CTRL;
		cfg_wdata = '0;
		in_valid = 1'b0;
		in_group = '0;
		calc_en = 1'b0;
		aborted = 1'b0;
		pass_cnt = 0;
		fail_cnt = 0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		fd = $fopen("conv_point_vectors.txt", "r");
		if (fd == 0) begin
			$display("cannot open conv_point_vectors.txt");
			fail_cnt++;
		end else begin
			while (!aborted && $fgets(line, fd) != 0) begin
				n = $sscanf(line, "%s", tag);
				if (n != 1 || tag == "#") begin
					continue; // blank or comment line
				end
				if (tag == "W") begin
					n = $sscanf(line, "%s %h %h", tag, a, d);
					drive_write(a[3:0], d);
				end else if (tag == "B") begin
					n = $sscanf(line, "%s %h %h %h %h %h", tag, f0, f1, f2, f3, lst);
					drive_beat({f3, f2, f1, f0}, lst);
				end else if (tag == "E") begin
					n = $sscanf(line, "%s %s %h %h %h", tag, name, d, up, dn);
					check_result(name, d[15:0], up, dn);
				end else if (tag == "I") begin
					n = $sscanf(line, "%s %s %h", tag, name, up);
					check_itr(name, up);
				end else if (tag == "X") begin
					n = $sscanf(line, "%s %s", tag, name);
					check_silent(name);
				end else begin
					$display("unknown record %s in the vector file", tag);
					fail_cnt++;
				end
			end
			$fclose(fd);
		end
		if (!aborted && (res_q.size() != 0 || exp_cyc_q.size() != 0)) begin
			$display("results left over that no expected record matched");
			fail_cnt++;
		end
		$display("tests passed: %0d  failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
